/* ecc_pkg.sv */
package ecc_pkg;

    // **********************************************************************
    // Code dimensions
    // **********************************************************************

    localparam int data_bits  = 94;
    localparam int check_bits = 8;
    localparam int index_bits = 7;   // Enough to address all 94 data bits

    typedef logic [data_bits-1:0]  data_word_t;
    typedef logic [check_bits-1:0] check_word_t;

    // Syndrome classes as seen by the decoder
    typedef enum logic [1:0] {
        err_none  = 2'd0,
        err_data  = 2'd1,
        err_check = 2'd2,
        err_multi = 2'd3
    } err_class_t;

    // **********************************************************************
    // Pipeline stage registers
    // **********************************************************************

    // Word as it leaves the encode stage
    typedef struct packed {
        data_word_t  data;
        check_word_t check_stored;   // Check bits that came in with the word
        check_word_t check_calc;     // Check bits computed from the word
        logic        bypass;
    } enc_stage_t;

    // Word as it leaves the syndrome stage
    typedef struct packed {
        data_word_t            data;
        check_word_t           check_calc;
        logic                  bypass;
        err_class_t            err_class;
        logic [index_bits-1:0] bit_index;   // Failing data bit for err_data
    } dec_stage_t;

    // **********************************************************************
    // Code construction
    // **********************************************************************

    // Data bit idx sits at the idx-th position from 3 upward that is not a
    // power of two, so bit 0 lands on 3 and bit 93 on 101
    function automatic int unsigned hamming_position(input int unsigned idx);
        int unsigned pos;
        int unsigned seen;
        pos  = 0;
        seen = 0;
        for (int unsigned p = 3; p < 128; p++) begin
            if ((p & (p - 1)) != 0) begin   // Powers of two hold check bits
                if (seen == idx) begin
                    pos = p;
                end
                seen++;
            end
        end
        return pos;
    endfunction

    // Column of the parity check matrix for one data bit. The low seven
    // bits are the Hamming position and bit 7 is set for positions with an
    // even number of ones, which leaves every data column with odd weight
    function automatic check_word_t check_column(input int unsigned idx);
        int unsigned pos;
        check_word_t col;
        pos = hamming_position(idx);
        col[check_bits-2:0] = pos[check_bits-2:0];
        col[check_bits-1]   = ~^pos[check_bits-2:0];
        return col;
    endfunction

endpackage

/* ecc_encode_stage.sv */
module ecc_encode_stage import ecc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  data_word_t  data_in,
    input  check_word_t check_in,
    input  logic        bypass,
    output enc_stage_t  enc
);

    check_word_t check_calc;

    // Selects the data bits that feed check bit row
    function automatic data_word_t tree_select(input int unsigned row);
        data_word_t  sel;
        check_word_t col;
        sel = '0;
        for (int unsigned i = 0; i < data_bits; i++) begin
            col    = check_column(i);
            sel[i] = col[row];
        end
        return sel;
    endfunction

    // **********************************************************************
    // Parity trees
    // **********************************************************************

    // One XOR reduction per check bit, each over a fixed subset of the word
    for (genvar j = 0; j < check_bits; j++) begin : g_tree
        localparam data_word_t tree_sel = tree_select(j);

        assign check_calc[j] = ^(data_in & tree_sel);
    end

    // **********************************************************************
    // Stage register
    // **********************************************************************

    // Check bits are still computed under bypass so check_out stays valid
    always_ff @(posedge clk) begin
        if (reset) begin
            enc <= '0;
        end else begin
            enc.data         <= data_in;
            enc.check_stored <= check_in;
            enc.check_calc   <= check_calc;
            enc.bypass       <= bypass;
        end
    end

endmodule

/* ecc_syndrome_stage.sv */
module ecc_syndrome_stage import ecc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  enc_stage_t enc,
    output dec_stage_t dec
);

    check_word_t           syndrome;
    logic                  column_hit;
    logic [index_bits-1:0] bit_index;
    err_class_t            err_class;

    assign syndrome = enc.check_stored ^ enc.check_calc;

    // **********************************************************************
    // Column match
    // **********************************************************************

    // Every data column is distinct, so at most one index can match
    always_comb begin
        column_hit = 1'b0;
        bit_index  = '0;
        for (int unsigned i = 0; i < data_bits; i++) begin
            if (syndrome == check_column(i)) begin
                column_hit = 1'b1;
                bit_index  = index_bits'(i);
            end
        end
    end

    // **********************************************************************
    // Classification
    // **********************************************************************

    // Data columns all have weight three or more and never look like a
    // single check bit, so the order of the tests below does not matter
    always_comb begin
        if (syndrome == '0) begin
            err_class = err_none;
        end else if ($onehot(syndrome)) begin
            err_class = err_check;   // Only a stored check bit flipped
        end else if (column_hit) begin
            err_class = err_data;
        end else begin
            err_class = err_multi;   // Even weight or an unused odd column
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec <= '0;
        end else begin
            dec.data       <= enc.data;
            dec.check_calc <= enc.check_calc;
            dec.bypass     <= enc.bypass;
            dec.err_class  <= err_class;
            dec.bit_index  <= bit_index;
        end
    end

    // The correct stage flips data[bit_index] without a range check
    a_index_range : assert property (
        @(posedge clk) disable iff (reset)
        dec.err_class == err_data |-> dec.bit_index < data_bits
    );

endmodule

/* ecc_correct_stage.sv */
module ecc_correct_stage import ecc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  dec_stage_t  dec,
    output data_word_t  data_out,
    output check_word_t check_out,
    output logic        single_err,
    output logic        double_err
);

    data_word_t data_fixed;
    logic       flag_single;
    logic       flag_double;

    // **********************************************************************
    // Correction
    // **********************************************************************

    always_comb begin
        data_fixed = dec.data;
        if (dec.err_class == err_data && !dec.bypass) begin
            data_fixed[dec.bit_index] = ~dec.data[dec.bit_index];
        end
    end

    // Bypass hides every error report
    assign flag_single = !dec.bypass && (dec.err_class inside {err_data, err_check});
    assign flag_double = !dec.bypass && (dec.err_class == err_multi);

    // **********************************************************************
    // Output register
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            data_out   <= '0;
            check_out  <= '0;
            single_err <= 1'b0;
            double_err <= 1'b0;
        end else begin
            data_out   <= data_fixed;
            check_out  <= dec.check_calc;   // Fresh check bits of the input word
            single_err <= flag_single;
            double_err <= flag_double;
        end
    end

    // A word is either correctable or not, never both
    a_flags_exclusive : assert property (
        @(posedge clk) !(single_err && double_err)
    );

    a_flags_after_reset : assert property (
        @(posedge clk) reset |=> !single_err && !double_err
    );

endmodule

/* ecc_94_top.sv */
module ecc_94_top import ecc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  data_word_t  data_in,
    input  check_word_t check_in,
    input  logic        bypass,
    output data_word_t  data_out,
    output check_word_t check_out,
    output logic        single_err,
    output logic        double_err
);

    // **********************************************************************
    // Three stage pipeline with a fixed latency of three clocks
    // **********************************************************************

    enc_stage_t enc;   // Encode to syndrome
    dec_stage_t dec;   // Syndrome to correct

    ecc_encode_stage ecc_encode_stage_inst (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in),
        .check_in (check_in),
        .bypass   (bypass),
        .enc      (enc)
    );

    ecc_syndrome_stage ecc_syndrome_stage_inst (
        .clk   (clk),
        .reset (reset),
        .enc   (enc),
        .dec   (dec)
    );

    ecc_correct_stage ecc_correct_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .data_out   (data_out),
        .check_out  (check_out),
        .single_err (single_err),
        .double_err (double_err)
    );

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period_ns = 2;   // 4 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #half_period_ns clk = ~clk;
        end
    end

endmodule

/* ecc_94_tb.sv */
module ecc_94_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int data_width    = 94;
    localparam int check_width   = 8;
    localparam int clk_period_ns = 4;

    localparam int n_clean  = 40;
    localparam int n_data   = data_width;        // One word per data bit
    localparam int n_check  = 2 * check_width;   // Every check bit twice
    localparam int n_double = 40;
    localparam int n_bypass = 20;
    localparam int total_words = n_clean + n_data + n_check + n_double + n_bypass;

    typedef struct packed {
        logic [data_width-1:0]  data;
        logic [check_width-1:0] check;
        logic                   single;
        logic                   dbl;
    } expected_t;

    logic                   clk;
    logic                   reset;
    logic [data_width-1:0]  data_in;
    logic [check_width-1:0] check_in;
    logic                   bypass;
    logic [data_width-1:0]  data_out;
    logic [check_width-1:0] check_out;
    logic                   single_err;
    logic                   double_err;

    expected_t   expected_q[$];
    logic [31:0] lcg_state = 32'h204f_a0d9;
    logic        first_sent = 1'b0;
    logic        checks_done = 1'b0;
    event        first_word;

    tb_clock_gen tb_clock_gen_inst (
        .clk (clk)
    );

    ecc_94_top ecc_94_top_inst (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .check_in   (check_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .check_out  (check_out),
        .single_err (single_err),
        .double_err (double_err)
    );

    // **********************************************************************
    // Reference model of the code
    // **********************************************************************

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [data_width-1:0] random_word();
        logic [95:0] bits;
        bits = {lcg_next(), lcg_next(), lcg_next()};
        return bits[data_width-1:0];
    endfunction

    // Skip every power of two, starting the count at position 3
    function automatic int position_of(input int idx);
        int pos;
        int count;
        pos   = 2;
        count = -1;
        while (count < idx) begin
            pos++;
            if ($countones(pos) != 1) count++;
        end
        return pos;
    endfunction

    function automatic logic [check_width-1:0] column_of(input int idx);
        int                     pos;
        logic [check_width-1:0] col;
        pos      = position_of(idx);
        col[6:0] = pos[6:0];
        col[7]   = ($countones(pos[6:0]) % 2 == 0);   // Pads the column to odd weight
        return col;
    endfunction

    function automatic logic [check_width-1:0] encode_word(input logic [data_width-1:0] data);
        logic [check_width-1:0] chk;
        chk = '0;
        for (int i = 0; i < data_width; i++) begin
            if (data[i]) chk ^= column_of(i);
        end
        return chk;
    endfunction

    function automatic expected_t decode_word(input logic [data_width-1:0]  data,
                                              input logic [check_width-1:0] stored,
                                              input logic                   byp);
        expected_t              r;
        logic [check_width-1:0] syn;
        r.data   = data;
        r.check  = encode_word(data);
        r.single = 1'b0;
        r.dbl    = 1'b0;
        syn      = stored ^ r.check;
        if (!byp && syn != '0) begin
            if ($countones(syn) == 1) begin
                r.single = 1'b1;   // Check bit error, data untouched
            end else begin
                r.dbl = 1'b1;
                for (int i = 0; i < data_width; i++) begin
                    if (column_of(i) == syn) begin
                        r.data[i] = ~r.data[i];
                        r.single  = 1'b1;
                        r.dbl     = 1'b0;
                    end
                end
            end
        end
        return r;
    endfunction

    // **********************************************************************
    // Checks and stimulus helpers
    // **********************************************************************

    task automatic check_value(input string name,
                               input logic [data_width-1:0] actual,
                               input logic [data_width-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s actual %h expected %h", name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic check_idle();
        check_value("data_out", data_out, '0);
        check_value("single_err", single_err, '0);
        check_value("double_err", double_err, '0);
    endtask

    // Positions 0 to 93 are data bits, 94 to 101 are stored check bits
    task automatic flip_position(inout logic [data_width-1:0]  data,
                                 inout logic [check_width-1:0] chk,
                                 input int                     pos);
        if (pos < data_width) data[pos] = ~data[pos];
        else chk[pos-data_width] = ~chk[pos-data_width];
    endtask

    task automatic drive_word(input logic [data_width-1:0]  data,
                              input logic [check_width-1:0] chk,
                              input logic                   byp);
        @(negedge clk);
        data_in  = data;
        check_in = chk;
        bypass   = byp;
        expected_q.push_back(decode_word(data, chk, byp));
        if (!first_sent) begin
            first_sent = 1'b1;
            -> first_word;
        end
    endtask

    // **********************************************************************
    // Stimulus
    // **********************************************************************

    initial begin : stimulus
        logic [data_width-1:0]  data;
        logic [check_width-1:0] chk;
        int                     a;
        int                     b;
        reset    = 1'b1;
        data_in  = '0;
        check_in = '0;
        bypass   = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_idle();
        end
        reset = 1'b0;
        repeat (2) begin   // Idle zero words must leave the outputs clear
            @(negedge clk);
            check_idle();
        end

        for (int n = 0; n < n_clean; n++) begin
            data = random_word();
            drive_word(data, encode_word(data), 1'b0);
        end

        for (int i = 0; i < n_data; i++) begin
            data = random_word();
            chk  = encode_word(data);
            flip_position(data, chk, i);
            drive_word(data, chk, 1'b0);
        end

        for (int n = 0; n < n_check; n++) begin
            data = random_word();
            chk  = encode_word(data);
            flip_position(data, chk, data_width + (n % check_width));
            drive_word(data, chk, 1'b0);
        end

        for (int n = 0; n < n_double; n++) begin
            data = random_word();
            chk  = encode_word(data);
            a    = int'(lcg_next() % (data_width + check_width));
            b    = a;
            while (b == a) b = int'(lcg_next() % (data_width + check_width));
            flip_position(data, chk, a);
            flip_position(data, chk, b);
            drive_word(data, chk, 1'b0);
        end

        // Mix of single and double faults, all hidden by bypass
        for (int n = 0; n < n_bypass; n++) begin
            data = random_word();
            chk  = encode_word(data);
            a    = int'(lcg_next() % (data_width + check_width));
            flip_position(data, chk, a);
            if (n % 2 == 1) begin
                b = a;
                while (b == a) b = int'(lcg_next() % (data_width + check_width));
                flip_position(data, chk, b);
            end
            drive_word(data, chk, 1'b1);
        end

        wait (checks_done);
        $display("*** PASSED ***");
        $finish;
    end

    // **********************************************************************
    // Output comparison
    // **********************************************************************

    // A word driven at one falling edge is on the outputs by the third after it
    initial begin : compare_outputs
        expected_t exp;
        @(first_word);
        repeat (2) @(negedge clk);
        for (int n = 0; n < total_words; n++) begin
            @(negedge clk);
            if (expected_q.size() == 0) begin
                $display("The expected-value queue ran empty before all words were checked");
                $display("*** FAILED ***");
                $fatal(1, "Empty queue");
            end
            exp = expected_q.pop_front();
            check_value("data_out", data_out, exp.data);
            check_value("check_out", check_out, exp.check);
            check_value("single_err", single_err, exp.single);
            check_value("double_err", double_err, exp.dbl);
        end
        checks_done = 1'b1;
    end

    initial begin : watchdog
        #((total_words + 20) * clk_period_ns);
        $display("Watchdog expired because the run did not finish in the expected time");
        $display("*** FAILED ***");
        $fatal(1, "Timeout");
    end

endmodule

/* build.f */
ecc_pkg.sv
ecc_encode_stage.sv
ecc_syndrome_stage.sv
ecc_correct_stage.sv
ecc_94_top.sv
tb_clock_gen.sv
ecc_94_tb.sv
